//--- csr_unit.f
verilog/csr_pkg.sv
verilog/csr_trap_if.sv
verilog/csr_file.sv
verilog/csr_exec.sv
verilog/csr_trap_ctrl.sv
verilog/csr_unit.sv
testbench/tb_csr_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the csr_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_csr_unit
LOG=sim.log

verilator --binary --timing --assert \
    -f csr_unit.f \
    --top-module tb_csr_unit \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
exit 0

//--- testbench/csr_unit_vectors.txt
# name kind op addr src aux expected, all numbers hex; op 1=rw 2=rs 3=rc
# exc: src=code aux=pc; irq: aux=pc; stall: aux[7:0]=cycles, aux[8]=mem_wait
rw_scratch   op    1 340 12345678 0   0
rd_scratch   op    2 340 0        0   12345678
unk_write    op    1 7c0 deadbeef 0   0
unk_read     op    2 7c0 0        0   0
ms_set       op    2 300 88       0   0
ms_set2      op    2 300 1800     0   88
ms_clr       op    3 300 1080     0   1888
ms_read      op    2 300 0        0   808
chain_a      op    1 340 a        0   12345678
chain_b      op    2 340 50       0   a
chain_c      op    3 340 2        0   5a
chain_d      op    2 340 0        0   58
cush_a       op    1 340 77       0   58
cush_gap     op    2 7c0 0        0   0
cush_b       op    2 340 0        0   77
tvec_set     op    1 305 100      0   0
exc_ill      exc   0 0   2        400 100
exc_mepc     op    2 341 0        0   400
exc_mcause   op    2 342 0        0   2
exc_mstatus  op    2 300 0        0   80
irq_masked   irq   0 0   0        500 0
tvec_vec     op    1 305 101      0   100
mie_on       op    2 300 8        0   80
irq_vec      irq   0 0   0        500 12c
irq_mcause   op    2 342 0        0   8000000b
irq_mepc     op    2 341 0        0   500
irq_mstatus  op    2 300 0        0   80
stall_op     stall 1 340 cafe     3   77
wait_op      stall 2 340 1        103 cafe
flush_op     flush 1 340 ffff     0   0
flush_chk    op    2 340 0        0   caff

//--- testbench/tb_csr_unit.sv
`timescale 1ns/1ps

module tb_csr_unit;
    import csr_pkg::*;

    localparam int    TIMEOUT  = 20;
    localparam string VEC_FILE = "testbench/csr_unit_vectors.txt";

    logic      CLK = 1'b0;
    logic      RST;
    logic      flush;
    logic      stall;
    logic      mem_wait;
    logic      issue_valid;
    csr_op_e   issue_op;
    csr_addr_t issue_addr;
    xlen_t     issue_src;
    logic      exc_req;
    xlen_t     exc_code;
    xlen_t     exc_pc;
    logic      irq;
    logic      rd_valid;
    xlen_t     rd_data;
    logic      trap_taken;
    xlen_t     trap_target;

    // results still in flight, oldest first
    string     pend_name[$];
    xlen_t     pend_exp[$];
    xlen_t     model[csr_addr_t];

    int        checks;
    int        mismatches;
    int        timeouts;
    int        other_errs;

    csr_unit u_dut (
        .CLK         (CLK),
        .RST         (RST),
        .flush       (flush),
        .stall       (stall),
        .mem_wait    (mem_wait),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_addr  (issue_addr),
        .issue_src   (issue_src),
        .exc_req     (exc_req),
        .exc_code    (exc_code),
        .exc_pc      (exc_pc),
        .irq         (irq),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .trap_taken  (trap_taken),
        .trap_target (trap_target)
    );

    always #2 CLK = ~CLK;

    task automatic compare(input string name, input xlen_t expected, input xlen_t actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // advance one cycle, then collect a result if one is out
    task automatic tick();
        @(negedge CLK);
        if (rd_valid) begin
            if (pend_exp.size() == 0) begin
                other_errs++;
                $display("rd_valid was high at %0t with no operation pending", $time);
            end else begin
                compare(pend_name.pop_front(), pend_exp.pop_front(), rd_data);
            end
        end
    endtask

    // empty the pipe so the last write has landed
    task automatic drain();
        int n;
        n = 0;
        while (pend_exp.size() != 0 && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (pend_exp.size() != 0) begin
            timeouts++;
            $display("gave up waiting for the result of %s", pend_name[0]);
            pend_name.delete();
            pend_exp.delete();
        end
        repeat (2) tick();
    endtask

    function automatic void apply_op(input csr_op_e op, input csr_addr_t addr, input xlen_t src);
        if (model.exists(addr)) begin
            case (op)
                CSR_OP_RW: model[addr] = src;
                CSR_OP_RS: model[addr] = model[addr] | src;
                default:   model[addr] = model[addr] & ~src;
            endcase
        end
    endfunction

    function automatic void apply_trap(input xlen_t code, input xlen_t pc);
        xlen_t st;
        st = '0;
        st[MSTATUS_MPIE] = model[CSR_MSTATUS][MSTATUS_MIE];
        model[CSR_MSTATUS] = st;
        model[CSR_MEPC]    = pc;
        model[CSR_MCAUSE]  = code;
    endfunction

    task automatic issue(input string name, input csr_op_e op, input csr_addr_t addr,
                         input xlen_t src, input xlen_t expected);
        issue_valid = 1'b1;
        issue_op    = op;
        issue_addr  = addr;
        issue_src   = src;
        pend_name.push_back(name);
        pend_exp.push_back(expected);
        apply_op(op, addr, src);
        tick();
        issue_valid = 1'b0;
    endtask

    task automatic stalled_issue(input string name, input csr_op_e op, input csr_addr_t addr,
                                 input xlen_t src, input xlen_t hold, input xlen_t expected);
        int cycles;
        cycles      = {24'd0, hold[7:0]};
        issue_valid = 1'b1;
        issue_op    = op;
        issue_addr  = addr;
        issue_src   = src;
        if (hold[8]) begin
            mem_wait = 1'b1;
        end else begin
            stall = 1'b1;
        end
        // any rd_valid here finds an empty queue
        repeat (cycles) tick();
        stall    = 1'b0;
        mem_wait = 1'b0;
        issue(name, op, addr, src, expected);
    endtask

    task automatic flushed_issue(input csr_op_e op, input csr_addr_t addr, input xlen_t src);
        issue_valid = 1'b1;
        issue_op    = op;
        issue_addr  = addr;
        issue_src   = src;
        tick();
        issue_valid = 1'b0;
        flush       = 1'b1;
        tick();
        flush = 1'b0;
        repeat (3) tick();
    endtask

    task automatic wait_trap(input string name, input xlen_t expected);
        int n;
        n = 0;
        while (!trap_taken && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (!trap_taken) begin
            timeouts++;
            $display("%s: trap_taken never went high", name);
        end else begin
            compare(name, expected, trap_target);
        end
    endtask

    task automatic raise_exception(input string name, input xlen_t code, input xlen_t pc,
                                   input xlen_t expected);
        exc_req  = 1'b1;
        exc_code = code;
        exc_pc   = pc;
        tick();
        exc_req = 1'b0;
        wait_trap(name, expected);
        apply_trap(code, pc);
    endtask

    task automatic raise_interrupt(input string name, input xlen_t pc, input xlen_t expected);
        irq    = 1'b1;
        exc_pc = pc;
        if (model[CSR_MSTATUS][MSTATUS_MIE]) begin
            tick();
            wait_trap(name, expected);
            apply_trap(CAUSE_M_EXT_INT, pc);
            // level still high, but MIE is gone now
            repeat (3) begin
                tick();
                if (trap_taken) begin
                    other_errs++;
                    $display("%s: interrupt level was taken a second time", name);
                end
            end
        end else begin
            repeat (4) begin
                tick();
                if (trap_taken) begin
                    other_errs++;
                    $display("%s: interrupt was taken while MIE was clear", name);
                end
            end
        end
        irq = 1'b0;
    endtask

    initial begin
        int    fd;
        int    cnt;
        int    gap;
        int    lines_run;
        string line;
        string name;
        string kind;
        xlen_t op_f;
        xlen_t addr_f;
        xlen_t src_f;
        xlen_t aux_f;
        xlen_t exp_f;

        void'($urandom(32'h9a24));
        checks      = 0;
        mismatches  = 0;
        timeouts    = 0;
        other_errs  = 0;
        lines_run   = 0;
        RST         = 1'b1;
        flush       = 1'b0;
        stall       = 1'b0;
        mem_wait    = 1'b0;
        issue_valid = 1'b0;
        issue_op    = CSR_OP_RW;
        issue_addr  = '0;
        issue_src   = '0;
        exc_req     = 1'b0;
        exc_code    = '0;
        exc_pc      = '0;
        irq         = 1'b0;
        model[CSR_MSTATUS]  = '0;
        model[CSR_MTVEC]    = '0;
        model[CSR_MSCRATCH] = '0;
        model[CSR_MEPC]     = '0;
        model[CSR_MCAUSE]   = '0;

        repeat (16) @(negedge CLK);
        RST = 1'b0;

        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            other_errs++;
            $display("could not open the vector file %s", VEC_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cnt  = $fgets(line, fd);
                if (cnt == 0 || line.len() < 2 || line.getc(0) == 8'h23) begin
                    continue;
                end
                cnt = $sscanf(line, "%s %s %h %h %h %h %h",
                              name, kind, op_f, addr_f, src_f, aux_f, exp_f);
                if (cnt != 7) begin
                    other_errs++;
                    $display("could not parse vector line: %s", line);
                    continue;
                end
                lines_run++;
                if (kind != "op") begin
                    drain();
                    gap = $urandom % 4;
                    repeat (gap) tick();
                end
                if (kind == "op") begin
                    issue(name, csr_op_e'(op_f[1:0]), addr_f[11:0], src_f, exp_f);
                end else if (kind == "exc") begin
                    raise_exception(name, src_f, aux_f, exp_f);
                end else if (kind == "irq") begin
                    raise_interrupt(name, aux_f, exp_f);
                end else if (kind == "stall") begin
                    stalled_issue(name, csr_op_e'(op_f[1:0]), addr_f[11:0], src_f, aux_f, exp_f);
                end else if (kind == "flush") begin
                    flushed_issue(csr_op_e'(op_f[1:0]), addr_f[11:0], src_f);
                end else begin
                    other_errs++;
                    $display("unknown vector kind %s in line %s", kind, name);
                end
            end
            $fclose(fd);
        end

        if (lines_run == 0) begin
            other_errs++;
            $display("no vectors were read");
        end
        drain();

        $display("checks %0d, mismatches %0d, timeouts %0d, other errors %0d",
                 checks, mismatches, timeouts, other_errs);
        if (mismatches + timeouts + other_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- verilog/csr_unit.sv
`timescale 1ns/1ps

module csr_unit #(
    parameter csr_pkg::xlen_t RESET_MTVEC = '0,
    parameter bit             IRQ_ENABLE  = 1'b1
) (
    input  logic               CLK,
    input  logic               RST,
    input  logic               flush,
    input  logic               stall,
    input  logic               mem_wait,

    input  logic               issue_valid,
    input  csr_pkg::csr_op_e   issue_op,
    input  csr_pkg::csr_addr_t issue_addr,
    input  csr_pkg::xlen_t     issue_src,

    input  logic               exc_req,
    input  csr_pkg::xlen_t     exc_code,
    input  csr_pkg::xlen_t     exc_pc,
    input  logic               irq,

    output logic               rd_valid,
    output csr_pkg::xlen_t     rd_data,
    output logic               trap_taken,
    output csr_pkg::xlen_t     trap_target
);
    import csr_pkg::*;

    logic      cap_valid;
    csr_op_e   cap_op;
    csr_addr_t cap_addr;
    xlen_t     cap_src;
    xlen_t     rdata;

    logic      exec_en;
    csr_addr_t exec_addr;
    xlen_t     exec_data;
    logic      cush_en;
    csr_addr_t cush_addr;
    xlen_t     cush_data;

    csr_trap_if u_trap_if ();

    csr_file #(
        .RESET_MTVEC (RESET_MTVEC)
    ) u_file (
        .CLK         (CLK),
        .RST         (RST),
        .flush       (flush),
        .stall       (stall),
        .mem_wait    (mem_wait),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_addr  (issue_addr),
        .issue_src   (issue_src),
        .exec_en     (exec_en),
        .exec_addr   (exec_addr),
        .exec_data   (exec_data),
        .cush_en     (cush_en),
        .cush_addr   (cush_addr),
        .cush_data   (cush_data),
        .trap        (u_trap_if.file),
        .cap_valid   (cap_valid),
        .cap_op      (cap_op),
        .cap_addr    (cap_addr),
        .cap_src     (cap_src),
        .rdata       (rdata)
    );

    csr_exec u_exec (
        .CLK       (CLK),
        .RST       (RST),
        .flush     (flush),
        .stall     (stall),
        .mem_wait  (mem_wait),
        .cap_valid (cap_valid),
        .cap_op    (cap_op),
        .cap_addr  (cap_addr),
        .cap_src   (cap_src),
        .rdata     (rdata),
        .exec_en   (exec_en),
        .exec_addr (exec_addr),
        .exec_data (exec_data),
        .cush_en   (cush_en),
        .cush_addr (cush_addr),
        .cush_data (cush_data),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

    csr_trap_ctrl #(
        .IRQ_ENABLE (IRQ_ENABLE)
    ) u_trap_ctrl (
        .CLK         (CLK),
        .RST         (RST),
        .exc_req     (exc_req),
        .exc_code    (exc_code),
        .exc_pc      (exc_pc),
        .irq         (irq),
        .trap        (u_trap_if.ctrl),
        .trap_taken  (trap_taken),
        .trap_target (trap_target)
    );

endmodule

//--- verilog/csr_trap_ctrl.sv
`timescale 1ns/1ps

module csr_trap_ctrl #(
    parameter bit IRQ_ENABLE = 1'b1
) (
    input  logic           CLK,
    input  logic           RST,

    input  logic           exc_req,
    input  csr_pkg::xlen_t exc_code,
    input  csr_pkg::xlen_t exc_pc,
    input  logic           irq,

    csr_trap_if.ctrl       trap,

    output logic           trap_taken,
    output csr_pkg::xlen_t trap_target
);
    import csr_pkg::*;

    logic  take_exc;
    logic  take_int;
    logic  trap_is_int;
    xlen_t vec_offset;

    // one trap at a time, MIE is cleared by the time the next decision is made
    assign take_exc = exc_req && !trap.trap_en;
    assign take_int = IRQ_ENABLE && irq && trap.int_allow && !exc_req && !trap.trap_en;

    always_ff @(posedge CLK) begin
        if (RST) begin
            trap.trap_en <= 1'b0;
            trap_is_int  <= 1'b0;
        end else begin
            trap.trap_en <= take_exc || take_int;
            trap_is_int  <= take_int;
        end
    end

    always_ff @(posedge CLK) begin
        if (take_exc) begin
            trap.trap_code <= exc_code;
            trap.trap_pc   <= exc_pc;
        end else if (take_int) begin
            trap.trap_code <= CAUSE_M_EXT_INT;
            trap.trap_pc   <= exc_pc;
        end
    end

    // vectored mode only applies to interrupts
    assign vec_offset  = {{(XLEN-7){1'b0}}, trap.trap_code[4:0], 2'b00};
    assign trap_taken  = trap.trap_en;
    assign trap_target = (trap_is_int && (trap.vec_mode == TVEC_VECTORED)) ?
                         trap.vec_base + vec_offset : trap.vec_base;

    a_single_cycle_trap: assert property (@(posedge CLK) disable iff (RST)
        trap_taken |=> !trap_taken);

endmodule

//--- verilog/csr_exec.sv
`timescale 1ns/1ps

module csr_exec (
    input  logic               CLK,
    input  logic               RST,
    input  logic               flush,
    input  logic               stall,
    input  logic               mem_wait,

    input  logic               cap_valid,
    input  csr_pkg::csr_op_e   cap_op,
    input  csr_pkg::csr_addr_t cap_addr,
    input  csr_pkg::xlen_t     cap_src,
    input  csr_pkg::xlen_t     rdata,

    output logic               exec_en,
    output csr_pkg::csr_addr_t exec_addr,
    output csr_pkg::xlen_t     exec_data,
    output logic               cush_en,
    output csr_pkg::csr_addr_t cush_addr,
    output csr_pkg::xlen_t     cush_data,

    output logic               rd_valid,
    output csr_pkg::xlen_t     rd_data
);
    import csr_pkg::*;

    logic  frozen;
    xlen_t new_val;
    xlen_t exec_old;

    assign frozen = stall || mem_wait;

    always_comb begin
        case (cap_op)
            CSR_OP_RW: new_val = cap_src;
            CSR_OP_RS: new_val = rdata | cap_src;
            CSR_OP_RC: new_val = rdata & ~cap_src;
            default:   new_val = rdata;
        endcase
    end

    // exec stage, writes to unknown CSRs are dropped here
    always_ff @(posedge CLK) begin
        if (RST || flush) begin
            exec_en  <= 1'b0;
            rd_valid <= 1'b0;
        end else if (frozen) begin
            rd_valid <= 1'b0;
        end else begin
            exec_en  <= cap_valid && csr_is_known(cap_addr);
            rd_valid <= cap_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!frozen) begin
            exec_addr <= cap_addr;
            exec_data <= new_val;
            exec_old  <= rdata;
        end
    end

    assign rd_data = exec_old;

    // cushion stage, commits once then idles while frozen
    always_ff @(posedge CLK) begin
        if (RST || frozen) begin
            cush_en <= 1'b0;
        end else begin
            cush_en <= exec_en;
        end
    end

    always_ff @(posedge CLK) begin
        if (!frozen) begin
            cush_addr <= exec_addr;
            cush_data <= exec_data;
        end
    end

    a_no_commit_when_stalled: assert property (@(posedge CLK) disable iff (RST)
        $rose(cush_en) |-> $past(!(stall || mem_wait)));

endmodule

//--- verilog/csr_file.sv
`timescale 1ns/1ps

module csr_file #(
    parameter csr_pkg::xlen_t RESET_MTVEC = '0
) (
    input  logic               CLK,
    input  logic               RST,
    input  logic               flush,
    input  logic               stall,
    input  logic               mem_wait,

    input  logic               issue_valid,
    input  csr_pkg::csr_op_e   issue_op,
    input  csr_pkg::csr_addr_t issue_addr,
    input  csr_pkg::xlen_t     issue_src,

    input  logic               exec_en,
    input  csr_pkg::csr_addr_t exec_addr,
    input  csr_pkg::xlen_t     exec_data,
    input  logic               cush_en,
    input  csr_pkg::csr_addr_t cush_addr,
    input  csr_pkg::xlen_t     cush_data,

    csr_trap_if.file           trap,

    output logic               cap_valid,
    output csr_pkg::csr_op_e   cap_op,
    output csr_pkg::csr_addr_t cap_addr,
    output csr_pkg::xlen_t     cap_src,
    output csr_pkg::xlen_t     rdata
);
    import csr_pkg::*;

    xlen_t mstatus;
    xlen_t mtvec;
    xlen_t mscratch;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t file_rdata;
    logic  exec_hit;
    logic  cush_hit;

    assign trap.vec_mode  = mtvec[1:0];
    assign trap.vec_base  = {mtvec[XLEN-1:2], 2'b00};
    assign trap.int_allow = mstatus[MSTATUS_MIE];

    // input capture
    always_ff @(posedge CLK) begin
        if (RST || flush) begin
            cap_valid <= 1'b0;
        end else if (!(stall || mem_wait)) begin
            cap_valid <= issue_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!(stall || mem_wait)) begin
            cap_op   <= issue_op;
            cap_addr <= issue_addr;
            cap_src  <= issue_src;
        end
    end

    always_comb begin
        case (cap_addr)
            CSR_MSTATUS:  file_rdata = mstatus;
            CSR_MTVEC:    file_rdata = mtvec;
            CSR_MSCRATCH: file_rdata = mscratch;
            CSR_MEPC:     file_rdata = mepc;
            CSR_MCAUSE:   file_rdata = mcause;
            default:      file_rdata = '0;
        endcase
    end

    // newest in-flight value wins
    assign exec_hit = exec_en && (exec_addr == cap_addr);
    assign cush_hit = cush_en && (cush_addr == cap_addr);

    always_comb begin
        if (exec_hit) begin
            rdata = exec_data;
        end else if (cush_hit) begin
            rdata = cush_data;
        end else begin
            rdata = file_rdata;
        end
    end

    // trap update beats a committed write
    always_ff @(posedge CLK) begin
        if (RST) begin
            mstatus  <= '0;
            mtvec    <= RESET_MTVEC;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (trap.trap_en) begin
            mstatus               <= '0;
            mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE];
            mcause                <= trap.trap_code;
            mepc                  <= trap.trap_pc;
        end else if (cush_en) begin
            case (cush_addr)
                CSR_MSTATUS:  mstatus  <= cush_data;
                CSR_MTVEC:    mtvec    <= cush_data;
                CSR_MSCRATCH: mscratch <= cush_data;
                CSR_MEPC:     mepc     <= cush_data;
                CSR_MCAUSE:   mcause   <= cush_data;
                default:      ;
            endcase
        end
    end

    // nothing is ever forwarded for an unknown address so it reads zero
    a_unknown_reads_zero: assert property (@(posedge CLK) disable iff (RST)
        (cap_valid && !csr_is_known(cap_addr)) |-> (rdata == '0));

endmodule

//--- verilog/csr_trap_if.sv
`timescale 1ns/1ps

interface csr_trap_if;
    import csr_pkg::*;

    // trap request, one cycle pulse
    logic       trap_en;
    xlen_t      trap_code;
    xlen_t      trap_pc;

    // vector state and interrupt enable from the file
    logic [1:0] vec_mode;
    xlen_t      vec_base;
    logic       int_allow;

    modport ctrl (
        output trap_en, trap_code, trap_pc,
        input  vec_mode, vec_base, int_allow
    );

    modport file (
        input  trap_en, trap_code, trap_pc,
        output vec_mode, vec_base, int_allow
    );

endinterface

//--- verilog/csr_pkg.sv
package csr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [XLEN-1:0]       xlen_t;

    // machine-mode CSRs held by the unit
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;

    // low bits of funct3, immediate forms share the same code
    typedef enum logic [1:0] {
        CSR_OP_RW = 2'b01,
        CSR_OP_RS = 2'b10,
        CSR_OP_RC = 2'b11
    } csr_op_e;

    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    localparam xlen_t      CAUSE_M_EXT_INT = 32'h8000_000B;
    localparam logic [1:0] TVEC_VECTORED   = 2'd1;

    // true for the five implemented CSRs
    function automatic logic csr_is_known(csr_addr_t addr);
        case (addr)
            CSR_MSTATUS,
            CSR_MTVEC,
            CSR_MSCRATCH,
            CSR_MEPC,
            CSR_MCAUSE: return 1'b1;
            default:    return 1'b0;
        endcase
    endfunction

endpackage
